// File: hw/scope_acq.sv
`timescale 1ns/10ps

module scope_acq (
  input  logic                         bus,
  input  logic                         rst_n,
  input  scope_pkg::acq_cfg_t          cfg,
  input  scope_pkg::ctl_t              ctl,
  input  scope_pkg::chan_beat_t        beats [scope_pkg::n_chan],
  input  logic [scope_pkg::n_chan-1:0] edge_hit,
  input  logic                         credit_ret,
  output scope_pkg::pair_beat_t        sto,
  output logic [2:0]                   sts,
  output logic [scope_pkg::cnt_w-1:0]  drop_cnt
);

  // status flags
  logic acquiring;
  logic triggered;
  logic done;

  logic [scope_pkg::cnt_w-1:0] pre_cnt;
  logic [scope_pkg::cnt_w-1:0] pst_cnt;
  logic [scope_pkg::cnt_w-1:0] pst_nxt;
  logic [scope_pkg::crd_w-1:0] crd_cnt;

  logic ctl_any;
  logic cand;
  logic send;
  logic trg_hit;
  logic is_last;

  assign sts = {done, triggered, acquiring};

  //////////////////////////////
  // candidate and trigger
  //////////////////////////////

  // a control pulse owns the cycle
  assign ctl_any = ctl.rst | ctl.acq | ctl.stp;
  // channels emit together, channel 0 stands for all
  assign cand    = acquiring & ~ctl_any & beats[0].valid;
  assign send    = cand & (crd_cnt != '0);
  assign pst_nxt = pst_cnt + 1'b1;
  assign is_last = cand & triggered & (pst_nxt == cfg.pst);

  // sw pulse or selected edge, only once pre count is met
  assign trg_hit = acquiring & ~ctl_any & ~triggered & (pre_cnt >= cfg.pre) &
                   (ctl.trg | (cfg.trg_en & edge_hit[cfg.trg_sel]));

  //////////////////////////////
  // sequencer
  //////////////////////////////

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      acquiring <= 1'b0;
      triggered <= 1'b0;
      done      <= 1'b0;
      pre_cnt   <= '0;
      pst_cnt   <= '0;
    end else if (ctl.rst) begin
      acquiring <= 1'b0;
      triggered <= 1'b0;
      done      <= 1'b0;
    end else if (ctl.acq) begin
      // arm
      acquiring <= 1'b1;
      triggered <= 1'b0;
      done      <= 1'b0;
      pre_cnt   <= '0;
      pst_cnt   <= '0;
    end else if (ctl.stp) begin
      acquiring <= 1'b0;
    end else begin
      // pre count saturates at the configured value
      if (cand && !triggered && pre_cnt < cfg.pre) begin
        pre_cnt <= pre_cnt + 1'b1;
      end
      if (cand && triggered) begin
        pst_cnt <= pst_nxt;
      end
      if (is_last) begin
        acquiring <= 1'b0;
        done      <= 1'b1;
      end
      if (trg_hit) begin
        triggered <= 1'b1;
        // zero post count finishes on the trigger itself
        if (cfg.pst == '0) begin
          acquiring <= 1'b0;
          done      <= 1'b1;
        end
      end
    end
  end

  //////////////////////////////
  // output, credits and drops
  //////////////////////////////

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      sto <= '0;
    end else begin
      sto.valid <= send;
      sto.last  <= send & is_last;
      for (int i = 0; i < scope_pkg::n_chan; i++) begin
        sto.smp[i] <= beats[i].smp;
      end
    end
  end

  // one credit per sent pair, one back per return cycle
  always_ff @(posedge bus) begin
    if (!rst_n) begin
      crd_cnt <= scope_pkg::crd_w'(scope_pkg::credits_max);
    end else begin
      crd_cnt <= crd_cnt - scope_pkg::crd_w'(send) + scope_pkg::crd_w'(credit_ret);
    end
  end

  // pairs lost for lack of credit
  always_ff @(posedge bus) begin
    if (!rst_n) begin
      drop_cnt <= '0;
    end else if (ctl.rst) begin
      drop_cnt <= '0;
    end else if (cand && !send) begin
      drop_cnt <= drop_cnt + 1'b1;
    end
  end

endmodule

// File: hw/scope_chan.sv
`timescale 1ns/10ps

module scope_chan (
  input  logic                    bus,
  input  logic                    rst_n,
  input  scope_pkg::chan_cfg_t    cfg,
  input  logic                    clr,
  input  logic                    valid,
  input  scope_pkg::sample_t      sample,
  output scope_pkg::chan_beat_t   beat,
  output logic                    edge_hit
);

  localparam int unsigned ext_w = scope_pkg::dat_w + 2;

  // decimation phase and running sum
  logic        [scope_pkg::cnt_w-1:0] dec_cnt;
  logic signed [scope_pkg::sum_w-1:0] sum_acc;
  logic signed [scope_pkg::sum_w-1:0] sum_nxt;
  logic signed [scope_pkg::sum_w-1:0] sum_shr;

  // edge detector, widened so thresholds never wrap
  logic signed [ext_w-1:0] smp_x;
  logic signed [ext_w-1:0] lvl_x;
  logic signed [ext_w-1:0] hst_x;
  logic                    arm_c;
  logic                    fire_c;
  logic                    armed;

  //////////////////////////////
  // averager and decimator
  //////////////////////////////

  // sum including the current sample
  assign sum_nxt = sum_acc + scope_pkg::sum_w'(sample);
  assign sum_shr = sum_nxt >>> cfg.shr;

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      dec_cnt <= '0;
      sum_acc <= '0;
      beat    <= '0;
    end else begin
      beat.valid <= 1'b0;
      if (clr) begin
        // restart the phase
        dec_cnt <= '0;
        sum_acc <= '0;
      end else if (valid) begin
        if (dec_cnt == cfg.dec) begin
          dec_cnt    <= '0;
          sum_acc    <= '0;
          beat.valid <= 1'b1;
          // averaged result truncated to sample width
          beat.smp   <= cfg.avg ? sum_shr[scope_pkg::dat_w-1:0] : sample;
        end else begin
          dec_cnt <= dec_cnt + 1'b1;
          sum_acc <= sum_nxt;
        end
      end
    end
  end

  //////////////////////////////
  // hysteresis edge detector
  //////////////////////////////

  assign smp_x = ext_w'(beat.smp);
  assign lvl_x = ext_w'(cfg.lvl);
  assign hst_x = $signed({2'b00, cfg.hst});

  // rising arms below lvl-hst, falling above lvl+hst
  always_comb begin
    if (cfg.edg) begin
      arm_c  = smp_x > (lvl_x + hst_x);
      fire_c = smp_x <= lvl_x;
    end else begin
      arm_c  = smp_x < (lvl_x - hst_x);
      fire_c = smp_x >= lvl_x;
    end
  end

  // one pulse per crossing, then wait to rearm
  always_ff @(posedge bus) begin
    if (!rst_n) begin
      armed    <= 1'b0;
      edge_hit <= 1'b0;
    end else begin
      edge_hit <= 1'b0;
      if (beat.valid) begin
        if (armed && fire_c) begin
          edge_hit <= 1'b1;
          armed    <= 1'b0;
        end else if (arm_c) begin
          armed <= 1'b1;
        end
      end
    end
  end

endmodule

// File: hw/scope_pkg.sv
package scope_pkg;

  //////////////////////////////
  // sizes
  //////////////////////////////

  // channel count
  localparam int unsigned n_chan = 2;
  // adc sample width, signed
  localparam int unsigned dat_w = 14;
  // decimation, pre and post counters
  localparam int unsigned cnt_w = 16;
  // averaging shift
  localparam int unsigned shr_w = 4;
  // decoded bus address bits
  localparam int unsigned baw = 7;
  // accumulator wide enough for 2**cnt_w samples
  localparam int unsigned sum_w = dat_w + cnt_w;
  // trigger channel select width
  localparam int unsigned sel_w = (n_chan > 1) ? $clog2(n_chan) : 1;

  // output credits after reset
  localparam int unsigned credits_max = 8;
  localparam int unsigned crd_w = $clog2(credits_max + 1);

  //////////////////////////////
  // register map
  //////////////////////////////

  localparam logic [baw-1:0] reg_ctl  = 'h00;
  localparam logic [baw-1:0] reg_sts  = 'h04;
  localparam logic [baw-1:0] reg_pre  = 'h10;
  localparam logic [baw-1:0] reg_pst  = 'h14;
  localparam logic [baw-1:0] reg_trg  = 'h18;
  localparam logic [baw-1:0] reg_drop = 'h1c;
  localparam logic [baw-1:0] reg_lvl  = 'h50;
  localparam logic [baw-1:0] reg_hst  = 'h54;
  localparam logic [baw-1:0] reg_edg  = 'h58;
  localparam logic [baw-1:0] reg_avg  = 'h60;
  localparam logic [baw-1:0] reg_dec  = 'h64;
  localparam logic [baw-1:0] reg_shr  = 'h68;

  //////////////////////////////
  // types
  //////////////////////////////

  typedef logic signed [dat_w-1:0] sample_t;

  // system bus
  typedef struct packed {
    logic           wen;
    logic           ren;
    logic [baw-1:0] addr;
    logic [31:0]    wdata;
  } bus_req_t;

  typedef struct packed {
    logic        ack;
    logic        err;
    logic [31:0] rdata;
  } bus_rsp_t;

  // adc input, one sample per channel
  typedef struct packed {
    logic                   valid;
    sample_t [n_chan-1:0]   smp;
  } adc_beat_t;

  // decimated stream of one channel
  typedef struct packed {
    logic    valid;
    sample_t smp;
  } chan_beat_t;

  // merged output pair
  typedef struct packed {
    logic                 valid;
    logic                 last;
    sample_t [n_chan-1:0] smp;
  } pair_beat_t;

  // per channel settings, shared by all channels
  typedef struct packed {
    logic             avg;
    logic [cnt_w-1:0] dec;
    logic [shr_w-1:0] shr;
    sample_t          lvl;
    logic [dat_w-1:0] hst;
    logic             edg;
  } chan_cfg_t;

  typedef struct packed {
    logic [cnt_w-1:0] pre;
    logic [cnt_w-1:0] pst;
    logic [sel_w-1:0] trg_sel;
    logic             trg_en;
  } acq_cfg_t;

  // one cycle pulses from reg_ctl
  typedef struct packed {
    logic rst;
    logic acq;
    logic stp;
    logic trg;
  } ctl_t;

endpackage

// File: hw/scope_regs.sv
`timescale 1ns/10ps

module scope_regs (
  input  logic                         bus,
  input  logic                         rst_n,
  input  scope_pkg::bus_req_t          req,
  input  logic [2:0]                   acq_sts,
  input  logic [scope_pkg::cnt_w-1:0]  drop_cnt,
  output scope_pkg::bus_rsp_t          rsp,
  output scope_pkg::chan_cfg_t         chan_cfg,
  output scope_pkg::acq_cfg_t          acq_cfg,
  output scope_pkg::ctl_t              ctl
);

  // write to the control register in this cycle
  logic ctl_wr;

  assign ctl_wr = req.wen && (req.addr == scope_pkg::reg_ctl);

  //////////////////////////////
  // handshake and read data
  //////////////////////////////

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      rsp <= '0;
    end else begin
      // ack one cycle after any access
      rsp.ack <= req.wen | req.ren;
      rsp.err <= 1'b0;
      if (req.ren) begin
        case (req.addr)
          scope_pkg::reg_sts:
            rsp.rdata <= {29'd0, acq_sts};
          scope_pkg::reg_pre:
            rsp.rdata <= {{(32-scope_pkg::cnt_w){1'b0}}, acq_cfg.pre};
          scope_pkg::reg_pst:
            rsp.rdata <= {{(32-scope_pkg::cnt_w){1'b0}}, acq_cfg.pst};
          scope_pkg::reg_trg:
            rsp.rdata <= {{(31-scope_pkg::sel_w){1'b0}}, acq_cfg.trg_sel, acq_cfg.trg_en};
          scope_pkg::reg_drop:
            rsp.rdata <= {{(32-scope_pkg::cnt_w){1'b0}}, drop_cnt};
          // edge detector, level read back unsigned
          scope_pkg::reg_lvl:
            rsp.rdata <= {{(32-scope_pkg::dat_w){1'b0}}, chan_cfg.lvl};
          scope_pkg::reg_hst:
            rsp.rdata <= {{(32-scope_pkg::dat_w){1'b0}}, chan_cfg.hst};
          scope_pkg::reg_edg:
            rsp.rdata <= {31'd0, chan_cfg.edg};
          // averager and decimator
          scope_pkg::reg_avg:
            rsp.rdata <= {31'd0, chan_cfg.avg};
          scope_pkg::reg_dec:
            rsp.rdata <= {{(32-scope_pkg::cnt_w){1'b0}}, chan_cfg.dec};
          scope_pkg::reg_shr:
            rsp.rdata <= {{(32-scope_pkg::shr_w){1'b0}}, chan_cfg.shr};
          // reg_ctl is write only
          default:
            rsp.rdata <= '0;
        endcase
      end
    end
  end

  //////////////////////////////
  // configuration writes
  //////////////////////////////

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      chan_cfg <= '0;
      acq_cfg  <= '0;
    end else if (req.wen) begin
      case (req.addr)
        scope_pkg::reg_pre: acq_cfg.pre <= req.wdata[scope_pkg::cnt_w-1:0];
        scope_pkg::reg_pst: acq_cfg.pst <= req.wdata[scope_pkg::cnt_w-1:0];
        scope_pkg::reg_trg: begin
          acq_cfg.trg_en  <= req.wdata[0];
          acq_cfg.trg_sel <= req.wdata[scope_pkg::sel_w:1];
        end
        scope_pkg::reg_lvl: chan_cfg.lvl <= req.wdata[scope_pkg::dat_w-1:0];
        scope_pkg::reg_hst: chan_cfg.hst <= req.wdata[scope_pkg::dat_w-1:0];
        scope_pkg::reg_edg: chan_cfg.edg <= req.wdata[0];
        scope_pkg::reg_avg: chan_cfg.avg <= req.wdata[0];
        scope_pkg::reg_dec: chan_cfg.dec <= req.wdata[scope_pkg::cnt_w-1:0];
        scope_pkg::reg_shr: chan_cfg.shr <= req.wdata[scope_pkg::shr_w-1:0];
        default: ;
      endcase
    end
  end

  //////////////////////////////
  // control pulses
  //////////////////////////////

  // registered, live for exactly one cycle
  always_ff @(posedge bus) begin
    if (!rst_n) begin
      ctl <= '0;
    end else begin
      ctl.rst <= ctl_wr & req.wdata[0];
      ctl.acq <= ctl_wr & req.wdata[1];
      ctl.stp <= ctl_wr & req.wdata[2];
      ctl.trg <= ctl_wr & req.wdata[3];
    end
  end

endmodule

// File: hw/scope_top.sv
`timescale 1ns/10ps

module scope_top (
  input  logic                  bus,
  input  logic                  rst_n,
  input  scope_pkg::bus_req_t   req,
  input  scope_pkg::adc_beat_t  adc,
  input  logic                  credit_ret,
  output scope_pkg::bus_rsp_t   rsp,
  output scope_pkg::pair_beat_t sto
);

  // configuration and control from the register set
  scope_pkg::chan_cfg_t chan_cfg;
  scope_pkg::acq_cfg_t  acq_cfg;
  scope_pkg::ctl_t      ctl;

  // channel outputs into acquisition
  scope_pkg::chan_beat_t        beats [scope_pkg::n_chan];
  logic [scope_pkg::n_chan-1:0] edge_hit;

  // status back to the register set
  logic [2:0]                  acq_sts;
  logic [scope_pkg::cnt_w-1:0] drop_cnt;

  //////////////////////////////
  // register set
  //////////////////////////////

  scope_regs u_regs (
    .bus      (bus),
    .rst_n    (rst_n),
    .req      (req),
    .acq_sts  (acq_sts),
    .drop_cnt (drop_cnt),
    .rsp      (rsp),
    .chan_cfg (chan_cfg),
    .acq_cfg  (acq_cfg),
    .ctl      (ctl)
  );

  //////////////////////////////
  // channels
  //////////////////////////////

  for (genvar i = 0; i < scope_pkg::n_chan; i++) begin : g_chan
    scope_chan u_chan (
      .bus      (bus),
      .rst_n    (rst_n),
      .cfg      (chan_cfg),
      .clr      (ctl.rst),
      .valid    (adc.valid),
      .sample   (adc.smp[i]),
      .beat     (beats[i]),
      .edge_hit (edge_hit[i])
    );
  end

  //////////////////////////////
  // acquisition
  //////////////////////////////

  scope_acq u_acq (
    .bus        (bus),
    .rst_n      (rst_n),
    .cfg        (acq_cfg),
    .ctl        (ctl),
    .beats      (beats),
    .edge_hit   (edge_hit),
    .credit_ret (credit_ret),
    .sto        (sto),
    .sts        (acq_sts),
    .drop_cnt   (drop_cnt)
  );

endmodule

// File: project.f
hw/scope_pkg.sv
hw/scope_regs.sv
hw/scope_chan.sv
hw/scope_acq.sv
hw/scope_top.sv
tb/scope_sva.sv
tb/scope_tb.sv

// File: run.sh
#!/bin/sh
# build and run with Verilator, verdict from sim.log
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module scope_tb \
  -o scope_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/scope_sim > sim.log 2>&1
grep -qF '** FAIL **' sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -qF '** PASS **' sim.log || { echo "simulation stopped early, see sim.log"; exit 1; }
echo "simulation passed"

// File: tb/scope_sva.sv
`timescale 1ns/10ps

module scope_sva (
  input logic                        bus,
  input logic                        rst_n,
  input scope_pkg::bus_req_t         req,
  input scope_pkg::bus_rsp_t         rsp,
  input scope_pkg::pair_beat_t       sto,
  input logic                        credit_ret,
  input logic [scope_pkg::crd_w-1:0] crd_cnt
);

  // pairs seen on the output and not yet handed back
  int held;

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      held <= 0;
    end else begin
      held <= held + int'(sto.valid) - int'(credit_ret);
    end
  end

  //////////////////////////////
  // output credits
  //////////////////////////////

  // returns never push the count past its reset value
  a_crd_max: assert property (@(posedge bus) disable iff (!rst_n)
    crd_cnt <= scope_pkg::credits_max)
    else $error("credit counter above its maximum");

  // a pair leaves only while fewer than credits_max are outstanding
  a_crd_sto: assert property (@(posedge bus) disable iff (!rst_n)
    sto.valid |-> held < scope_pkg::credits_max)
    else $error("pair sent without a credit");

  //////////////////////////////
  // bus handshake
  //////////////////////////////

  a_ack: assert property (@(posedge bus) disable iff (!rst_n)
    (req.wen || req.ren) |=> rsp.ack)
    else $error("no ack one cycle after a request");

  // no ack without a request before it
  a_ack_req: assert property (@(posedge bus) disable iff (!rst_n)
    rsp.ack |-> $past(req.wen || req.ren))
    else $error("ack without a request");

endmodule

// credit counter lives inside the acquisition block
bind scope_top scope_sva u_sva (
  .bus        (bus),
  .rst_n      (rst_n),
  .req        (req),
  .rsp        (rsp),
  .sto        (sto),
  .credit_ret (credit_ret),
  .crd_cnt    (u_acq.crd_cnt)
);

// File: tb/scope_tb.sv
`timescale 1ns/10ps

module scope_tb;

  logic                  bus;
  logic                  rst_n;
  scope_pkg::bus_req_t   req;
  scope_pkg::adc_beat_t  adc;
  logic                  credit_ret;
  scope_pkg::bus_rsp_t   rsp;
  scope_pkg::pair_beat_t sto;

  // stimulus state
  int cyc;
  int ramp;
  int dir;
  int rx_cnt;
  bit hold;
  int due [$];

  // model config copy and control pulses
  int c_pre, c_pst, c_sel, c_en, c_avg, c_dec, c_shr, c_lvl, c_hst, c_edg;
  scope_pkg::ctl_t m_ctl;
  // model channels and edge detectors
  int                 m_cnt;
  longint             m_sum [2];
  bit                 m_bv;
  scope_pkg::sample_t m_bs [2];
  bit                 m_arm [2];
  logic [1:0]         m_edge;
  // model acquisition and credits
  bit m_acq, m_trgd, m_done;
  int m_pre, m_pst, m_crd, m_drop;
  // expected output after the next edge
  bit                 e_v;
  bit                 e_last;
  scope_pkg::sample_t e_s [2];

  scope_top DUT (
    .bus        (bus),
    .rst_n      (rst_n),
    .req        (req),
    .adc        (adc),
    .credit_ret (credit_ret),
    .rsp        (rsp),
    .sto        (sto)
  );

  initial begin
    bus = 1'b0;
    forever #50 bus = ~bus;
  end

  //////////////////////////////
  // reporting
  //////////////////////////////

  task automatic abort_run();
    $display("** FAIL **");
    $fatal(1, "run stopped on error");
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
      abort_run();
    end
  endtask

  // run limit
  always @(posedge bus) begin
    cyc <= cyc + 1;
    if (cyc >= 20000) begin
      $display("timeout after %0d cycles", cyc);
      abort_run();
    end
  end

  //////////////////////////////
  // bus tasks
  //////////////////////////////

  task automatic wait_ack();
    int n;
    n = 0;
    do begin
      @(posedge bus);
      n++;
      if (n > 8) begin
        $display("bus access got no acknowledge");
        abort_run();
      end
    end while (!rsp.ack);
    // error flag stays low on every access
    check("rsp.err", rsp.err, 0);
  endtask

  task automatic bus_write(input logic [6:0] a, input logic [31:0] d);
    scope_pkg::bus_req_t r;
    r       = '0;
    r.wen   = 1'b1;
    r.addr  = a;
    r.wdata = d;
    @(posedge bus);
    req <= r;
    @(posedge bus);
    req <= '0;
    wait_ack();
  endtask

  task automatic bus_read(input logic [6:0] a, output logic [31:0] d);
    scope_pkg::bus_req_t r;
    r      = '0;
    r.ren  = 1'b1;
    r.addr = a;
    @(posedge bus);
    req <= r;
    @(posedge bus);
    req <= '0;
    wait_ack();
    d = rsp.rdata;
  endtask

  // poll status until done
  task automatic wait_done();
    logic [31:0] s;
    int n;
    n = 0;
    do begin
      bus_read(scope_pkg::reg_sts, s);
      n++;
      if (n > 1000) begin
        $display("acquisition never reported done");
        abort_run();
      end
    end while (!s[2]);
  endtask

  //////////////////////////////
  // adc source and consumer
  //////////////////////////////

  always @(posedge bus) begin : drive
    bit v;
    if (!rst_n) begin
      adc        <= '0;
      credit_ret <= 1'b0;
    end else begin
      v = ($urandom % 4) != 0;
      // triangle ramp that turns at the rails
      if (v) begin
        ramp = ramp + dir * 97;
        if (ramp > 3000) dir = -1;
        if (ramp < -3000) dir = 1;
      end
      adc.valid  <= v;
      adc.smp[0] <= 14'(ramp + int'($urandom % 31) - 15);
      adc.smp[1] <= 14'(-ramp / 2 + int'($urandom % 31) - 15);
      // each pair hands back a credit 0 to 5 cycles later
      if (sto.valid) begin
        rx_cnt++;
        due.push_back(cyc + int'($urandom % 6));
      end
      credit_ret <= 1'b0;
      if (!hold && due.size() > 0 && due[0] <= cyc) begin
        void'(due.pop_front());
        credit_ret <= 1'b1;
      end
    end
  end

  //////////////////////////////
  // reference model
  //////////////////////////////

  always @(posedge bus) begin : model
    int s;
    bit any, cand, send, lst, trg, arm_c, fire;
    if (!rst_n) begin
      {c_pre, c_pst, c_sel, c_en, c_avg, c_dec, c_shr, c_lvl, c_hst, c_edg} = '0;
      m_ctl  = '0;
      m_cnt  = 0;
      m_sum  = '{0, 0};
      m_bv   = 0;
      m_arm  = '{0, 0};
      m_edge = '0;
      {m_acq, m_trgd, m_done} = '0;
      {m_pre, m_pst, m_drop} = '0;
      m_crd  = scope_pkg::credits_max;
      e_v    = 0;
    end else begin
      // outputs after the previous edge
      check("sto.valid", sto.valid, e_v);
      if (e_v) begin
        check("sto.last", sto.last, e_last);
        check("sto.smp0", sto.smp[0], e_s[0]);
        check("sto.smp1", sto.smp[1], e_s[1]);
      end
      check("edge_hit", DUT.edge_hit, m_edge);
      // acquisition on the current channel beat
      any  = m_ctl.rst | m_ctl.acq | m_ctl.stp;
      cand = m_acq && !any && m_bv;
      send = cand && m_crd > 0;
      lst  = cand && m_trgd && (((m_pst + 1) & 'hffff) == c_pst);
      trg  = m_acq && !any && !m_trgd && m_pre >= c_pre &&
             (m_ctl.trg || (c_en != 0 && m_edge[c_sel]));
      e_v    = send;
      e_last = send && lst;
      e_s    = m_bs;
      m_crd  = m_crd - int'(send) + int'(credit_ret);
      if (m_ctl.rst) m_drop = 0;
      else if (cand && !send) m_drop++;
      if (m_ctl.rst) begin
        {m_acq, m_trgd, m_done} = '0;
      end else if (m_ctl.acq) begin
        m_acq  = 1;
        m_trgd = 0;
        m_done = 0;
        m_pre  = 0;
        m_pst  = 0;
      end else if (m_ctl.stp) begin
        m_acq = 0;
      end else begin
        if (cand && !m_trgd && m_pre < c_pre) m_pre++;
        if (cand && m_trgd) m_pst = (m_pst + 1) & 'hffff;
        if (lst) begin
          m_acq  = 0;
          m_done = 1;
        end
        if (trg) begin
          m_trgd = 1;
          if (c_pst == 0) begin
            m_acq  = 0;
            m_done = 1;
          end
        end
      end
      // hysteresis on the decimated samples
      m_edge = '0;
      for (int i = 0; i < 2; i++) begin
        if (m_bv) begin
          s = int'(m_bs[i]);
          arm_c = c_edg != 0 ? s > c_lvl + c_hst : s < c_lvl - c_hst;
          fire  = c_edg != 0 ? s <= c_lvl : s >= c_lvl;
          if (m_arm[i] && fire) begin
            m_edge[i] = 1'b1;
            m_arm[i]  = 0;
          end else if (arm_c) begin
            m_arm[i] = 1;
          end
        end
      end
      // averaging and decimation
      m_bv = 0;
      if (m_ctl.rst) begin
        m_cnt = 0;
        m_sum = '{0, 0};
      end else if (adc.valid) begin
        if (m_cnt == c_dec) begin
          m_cnt = 0;
          m_bv  = 1;
          for (int i = 0; i < 2; i++) begin
            s = int'($signed(adc.smp[i]));
            m_bs[i]  = c_avg != 0 ? 14'((m_sum[i] + s) >>> c_shr) : 14'(s);
            m_sum[i] = 0;
          end
        end else begin
          m_cnt = (m_cnt + 1) & 'hffff;
          for (int i = 0; i < 2; i++) m_sum[i] += int'($signed(adc.smp[i]));
        end
      end
      // register writes land one cycle later
      if (req.wen) begin
        case (req.addr)
          scope_pkg::reg_pre: c_pre = int'(req.wdata[15:0]);
          scope_pkg::reg_pst: c_pst = int'(req.wdata[15:0]);
          scope_pkg::reg_trg: begin
            c_en  = int'(req.wdata[0]);
            c_sel = int'(req.wdata[1]);
          end
          scope_pkg::reg_lvl: c_lvl = int'($signed(req.wdata[13:0]));
          scope_pkg::reg_hst: c_hst = int'(req.wdata[13:0]);
          scope_pkg::reg_edg: c_edg = int'(req.wdata[0]);
          scope_pkg::reg_avg: c_avg = int'(req.wdata[0]);
          scope_pkg::reg_dec: c_dec = int'(req.wdata[15:0]);
          scope_pkg::reg_shr: c_shr = int'(req.wdata[3:0]);
          default: ;
        endcase
      end
      m_ctl.rst = req.wen && req.addr == scope_pkg::reg_ctl && req.wdata[0];
      m_ctl.acq = req.wen && req.addr == scope_pkg::reg_ctl && req.wdata[1];
      m_ctl.stp = req.wen && req.addr == scope_pkg::reg_ctl && req.wdata[2];
      m_ctl.trg = req.wen && req.addr == scope_pkg::reg_ctl && req.wdata[3];
    end
  end

  //////////////////////////////
  // test sequences
  //////////////////////////////

  task automatic check_readback();
    logic [6:0]  addrs [9];
    logic [31:0] masks [9];
    logic [31:0] val;
    logic [31:0] rd;
    addrs = '{scope_pkg::reg_pre, scope_pkg::reg_pst, scope_pkg::reg_trg,
              scope_pkg::reg_lvl, scope_pkg::reg_hst, scope_pkg::reg_edg,
              scope_pkg::reg_avg, scope_pkg::reg_dec, scope_pkg::reg_shr};
    masks = '{'hffff, 'hffff, 'h3, 'h3fff, 'h3fff, 'h1, 'h1, 'hffff, 'hf};
    for (int i = 0; i < 9; i++) begin
      val = $urandom;
      bus_write(addrs[i], val);
      bus_read(addrs[i], rd);
      check("readback", rd, val & masks[i]);
    end
    // holes in the map
    bus_read(7'h20, rd);
    check("unmapped_20", rd, 0);
    bus_read(7'h7c, rd);
    check("unmapped_7c", rd, 0);
  endtask

  // channel settings then a ctl reset to restart the phase
  task automatic configure(input int avg, input int dec, input int shr);
    bus_write(scope_pkg::reg_avg, avg);
    bus_write(scope_pkg::reg_dec, dec);
    bus_write(scope_pkg::reg_shr, shr);
    bus_write(scope_pkg::reg_trg, 0);
    bus_write(scope_pkg::reg_ctl, 'h1);
  endtask

  // arm and fire the software trigger
  task automatic run_sw(input int pre, input int pst);
    bus_write(scope_pkg::reg_pre, pre);
    bus_write(scope_pkg::reg_pst, pst);
    bus_write(scope_pkg::reg_ctl, 'h2);
    bus_write(scope_pkg::reg_ctl, 'h8);
    wait_done();
  endtask

  initial begin
    logic [31:0] rd;
    int rx0;
    void'($urandom(32'h42d));
    rst_n      = 1'b0;
    req        = '0;
    adc        = '0;
    credit_ret = 1'b0;
    ramp       = 0;
    dir        = 1;
    hold       = 0;
    repeat (10) @(posedge bus);
    rst_n <= 1'b1;

    check_readback();

    // averaging on then off
    for (int r = 0; r < 5; r++) begin
      configure(r < 3, $urandom % 8, $urandom % 16);
      run_sw(0, 6 + $urandom % 10);
    end

    // edge trigger on ramp and noise
    for (int r = 0; r < 3; r++) begin
      configure(0, $urandom % 4, 0);
      bus_write(scope_pkg::reg_lvl, (int'($urandom % 2001) - 1000) & 'h3fff);
      bus_write(scope_pkg::reg_hst, $urandom % 301);
      bus_write(scope_pkg::reg_edg, $urandom % 2);
      bus_write(scope_pkg::reg_trg, (($urandom % 2) << 1) | 1);
      bus_write(scope_pkg::reg_pre, $urandom % 16);
      bus_write(scope_pkg::reg_pst, 4 + $urandom % 27);
      bus_write(scope_pkg::reg_ctl, 'h2);
      wait_done();
    end

    // early software trigger is ignored
    configure(0, 1, 0);
    bus_write(scope_pkg::reg_pre, 30);
    bus_write(scope_pkg::reg_pst, 8);
    bus_write(scope_pkg::reg_ctl, 'h2);
    bus_write(scope_pkg::reg_ctl, 'h8);
    bus_read(scope_pkg::reg_sts, rd);
    check("sts.triggered_early", rd[1], 0);
    while (m_pre < 30) @(posedge bus);
    bus_write(scope_pkg::reg_ctl, 'h8);
    wait_done();
    bus_read(scope_pkg::reg_sts, rd);
    check("sts.triggered", rd[1], 1);

    // credits withheld
    configure(0, 0, 0);
    hold = 1;
    rx0  = rx_cnt;
    run_sw(0, 40);
    check("pairs_without_return", (rx_cnt - rx0) <= scope_pkg::credits_max, 1);
    bus_read(scope_pkg::reg_drop, rd);
    check("drop_cnt", rd, m_drop);
    hold = 0;
    while (m_crd < scope_pkg::credits_max) @(posedge bus);

    // stop mid run
    configure(1, 3, 2);
    bus_write(scope_pkg::reg_pre, 0);
    bus_write(scope_pkg::reg_pst, 1000);
    bus_write(scope_pkg::reg_ctl, 'h2);
    repeat (30) @(posedge bus);
    bus_write(scope_pkg::reg_ctl, 'h4);
    bus_read(scope_pkg::reg_sts, rd);
    check("sts.acquiring", rd[0], 0);
    check("sts.done", rd[2], 0);

    // ctl reset restarts the decimation phase
    configure(1, 4, 1);
    run_sw(0, 12);

    repeat (20) @(posedge bus);
    $display("** PASS **");
    $finish;
  end

endmodule
